// File: files.f
+incdir+include
hdl/axil_pkg.sv
hdl/regs_pkg.sv
hdl/axil_addr_decode.sv
hdl/axil_resp_buffer.sv
hdl/axil_reg_file.sv
hdl/axil_regs.sv
tests/tb_axil_regs.sv

// File: hdl/axil_addr_decode.sv
// Address and protection decoder for one AXI4-Lite address channel.
// Instantiated once for AW and once for AR; purely combinational.
`timescale 1ns/1ns
`include "regs_config.svh"

module axil_addr_decode (
  input  axil_pkg::addr_u    addr_i,
  input  axil_pkg::prot_t    prot_i,
  output regs_pkg::reg_idx_t idx_o,
  output logic               allowed_o
);
  import axil_pkg::*;

  // Fixed base of the region.
  localparam logic [`REGS_ADDR_WIDTH-1:0] base_addr = `REGS_BASE_ADDR;

  logic tag_hit;
  logic priv_ok;
  logic secure_ok;

  // Region hit when the upper bits equal those of the base.
  // The base is aligned, so no adder is needed.
  assign tag_hit = (addr_i.fields.tag == base_addr[`REGS_ADDR_WIDTH-1:`REGS_ADDR_WIDTH-tag_width]);

  // Index sits right above the byte offset.
  // Byte offset bits are ignored, as usual on AXI4-Lite.
  assign idx_o = addr_i.fields.idx;

  // Privilege bit only matters when the policy asks for it.
  assign priv_ok = ~`REGS_PRIV_ONLY | prot_i[prot_priv_bit];

  // Same for the secure bit.
  assign secure_ok = ~`REGS_SECURE_ONLY | prot_i[prot_secure_bit];

  // Access goes through only inside the region and with a legal AxPROT.
  assign allowed_o = tag_hit & priv_ok & secure_ok;

endmodule

// File: hdl/axil_pkg.sv
// Bus-side types of the AXI4-Lite register block.
// Response codes, the address word with its decoded view, and AxPROT bit positions.
`include "regs_config.svh"

package axil_pkg;

  // Byte offset within one bus word.
  localparam int unsigned off_width = $clog2(`REGS_DATA_WIDTH / 8);
  // Register index bits of the address.
  localparam int unsigned idx_width = $clog2(`REGS_NUM);
  // Remaining upper bits select the region.
  localparam int unsigned tag_width = `REGS_ADDR_WIDTH - idx_width - off_width;

  // AxPROT bit positions.
  localparam int unsigned prot_priv_bit = 0;
  localparam int unsigned prot_secure_bit = 1;

  // AXI response codes used by this slave.
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_e;

  // Decoded view of one address word.
  typedef struct packed {
    logic [tag_width-1:0] tag;
    logic [idx_width-1:0] idx;
    logic [off_width-1:0] off;
  } addr_fields_t;

  // Address as it comes off the bus, or split into its fields.
  typedef union packed {
    logic [`REGS_ADDR_WIDTH-1:0] raw;
    addr_fields_t                fields;
  } addr_u;

  typedef logic [2:0] prot_t;
  typedef logic [`REGS_DATA_WIDTH-1:0] data_t;
  typedef logic [`REGS_DATA_WIDTH/8-1:0] strb_t;

endpackage

// File: hdl/axil_reg_file.sv
// Register storage of the AXI4-Lite register block.
// Applies hardware loads and strobed AXI writes, decides write acceptance and
// the B response, and returns the register selected for a read.
`timescale 1ns/1ns
`include "regs_config.svh"

module axil_reg_file (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 aw_valid_i,
  input  logic                 w_valid_i,
  output logic                 aw_ready_o,
  output logic                 w_ready_o,
  input  regs_pkg::reg_idx_t   wr_idx_i,
  input  logic                 wr_allowed_i,
  input  axil_pkg::data_t      w_data_i,
  input  axil_pkg::strb_t      w_strb_i,
  input  logic                 b_ready_i,
  output logic                 b_push_o,
  output axil_pkg::resp_e      b_resp_o,
  input  regs_pkg::reg_idx_t   rd_idx_i,
  output axil_pkg::data_t      rd_data_o,
  input  regs_pkg::reg_mask_t  reg_load_i,
  input  regs_pkg::reg_array_t reg_d_i,
  output regs_pkg::reg_array_t reg_q_o
);
  import axil_pkg::*;
  import regs_pkg::*;

  localparam reg_mask_t  read_only    = `REGS_READ_ONLY;
  localparam reg_array_t reset_values = `REGS_RESET_VALUES;

  reg_array_t reg_q;
  reg_array_t reg_d;

  logic wr_req;
  logic wr_ok;
  logic wr_stall;
  logic wr_accept;

  // Both AW and W must be present, and B needs room for the response.
  // b_ready_i comes from a flop in the buffer, so this adds no loop.
  assign wr_req = aw_valid_i & w_valid_i & b_ready_i;

  // A write that would really change a register.
  assign wr_ok = wr_allowed_i & ~read_only[wr_idx_i];

  // Hardware load on the same register has priority; the write waits.
  assign wr_stall = wr_ok & reg_load_i[wr_idx_i];

  // Rejected writes are taken at once and only produce SLVERR.
  assign wr_accept = wr_req & ~wr_stall;

  assign aw_ready_o = wr_accept;
  assign w_ready_o  = wr_accept;
  assign b_push_o   = wr_accept;
  assign b_resp_o   = wr_ok ? resp_okay : resp_slverr;

  // Next register values.
  always_comb begin
    reg_d = reg_q;

    // Hardware loads, read-only registers included.
    for (int unsigned i = 0; i < `REGS_NUM; i++) begin
      if (reg_load_i[i]) begin
        reg_d[i] = reg_d_i[i];
      end
    end

    // AXI write, bit by bit under the byte strobes.
    // Bus bits above the register width fall away here.
    if (wr_accept && wr_ok) begin
      for (int unsigned b = 0; b < `REGS_REG_WIDTH; b++) begin
        if (w_strb_i[b/8]) begin
          reg_d[wr_idx_i][b] = w_data_i[b];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_q <= reset_values;
    end else begin
      reg_q <= reg_d;
    end
  end

  assign reg_q_o = reg_q;

  // Read data, zero extended to the bus width.
  assign rd_data_o = data_t'(reg_q[rd_idx_i]);

endmodule

// File: hdl/axil_regs.sv
// AXI4-Lite register block, top level.
// Bus master reads and writes REGS_NUM registers; local hardware loads them
// through reg_load_i and reg_d_i and sees them on reg_q_o.
`timescale 1ns/1ns
`include "regs_config.svh"

module axil_regs (
  input  logic                        clk_i,
  input  logic                        reset_i,
  // AW channel.
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  logic [`REGS_ADDR_WIDTH-1:0] aw_addr_i,
  input  axil_pkg::prot_t             aw_prot_i,
  // W channel.
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  axil_pkg::data_t             w_data_i,
  input  axil_pkg::strb_t             w_strb_i,
  // B channel.
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output axil_pkg::resp_e             b_resp_o,
  // AR channel.
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  logic [`REGS_ADDR_WIDTH-1:0] ar_addr_i,
  input  axil_pkg::prot_t             ar_prot_i,
  // R channel.
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output axil_pkg::data_t             r_data_o,
  output axil_pkg::resp_e             r_resp_o,
  // Hardware side.
  input  regs_pkg::reg_mask_t         reg_load_i,
  input  regs_pkg::reg_array_t        reg_d_i,
  output regs_pkg::reg_array_t        reg_q_o
);
  import axil_pkg::*;
  import regs_pkg::*;

  localparam int unsigned b_width = $bits(resp_e);
  localparam int unsigned r_width = $bits(data_t) + $bits(resp_e);

  addr_u    aw_addr;
  addr_u    ar_addr;
  reg_idx_t wr_idx;
  reg_idx_t rd_idx;
  logic     wr_allowed;
  logic     rd_allowed;

  logic   b_push;
  logic   b_buf_ready;
  resp_e  b_push_resp;
  logic [b_width-1:0] b_word;

  data_t  rd_data;
  data_t  r_push_data;
  resp_e  r_push_resp;
  logic [r_width-1:0] r_push_word;
  logic [r_width-1:0] r_word;

  // Bus addresses enter through the raw view.
  assign aw_addr.raw = aw_addr_i;
  assign ar_addr.raw = ar_addr_i;

  axil_addr_decode i_aw_decode (
    .addr_i    (aw_addr),
    .prot_i    (aw_prot_i),
    .idx_o     (wr_idx),
    .allowed_o (wr_allowed)
  );

  axil_addr_decode i_ar_decode (
    .addr_i    (ar_addr),
    .prot_i    (ar_prot_i),
    .idx_o     (rd_idx),
    .allowed_o (rd_allowed)
  );

  axil_reg_file i_reg_file (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .aw_valid_i   (aw_valid_i),
    .w_valid_i    (w_valid_i),
    .aw_ready_o   (aw_ready_o),
    .w_ready_o    (w_ready_o),
    .wr_idx_i     (wr_idx),
    .wr_allowed_i (wr_allowed),
    .w_data_i     (w_data_i),
    .w_strb_i     (w_strb_i),
    .b_ready_i    (b_buf_ready),
    .b_push_o     (b_push),
    .b_resp_o     (b_push_resp),
    .rd_idx_i     (rd_idx),
    .rd_data_o    (rd_data),
    .reg_load_i   (reg_load_i),
    .reg_d_i      (reg_d_i),
    .reg_q_o      (reg_q_o)
  );

  // Write responses, one per accepted AW/W pair.
  axil_resp_buffer #(
    .WIDTH (b_width)
  ) i_b_buffer (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (b_push),
    .ready_o (b_buf_ready),
    .data_i  (b_push_resp),
    .valid_o (b_valid_o),
    .ready_i (b_ready_i),
    .data_o  (b_word)
  );

  assign b_resp_o = resp_e'(b_word);

  // Read word is built in the AR cycle.
  // Failed reads return the fixed error pattern.
  assign r_push_data = rd_allowed ? rd_data : data_t'(`REGS_ERR_DATA);
  assign r_push_resp = rd_allowed ? resp_okay : resp_slverr;
  assign r_push_word = {r_push_data, r_push_resp};

  // AR is taken whenever the R buffer has room.
  axil_resp_buffer #(
    .WIDTH (r_width)
  ) i_r_buffer (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .valid_i (ar_valid_i),
    .ready_o (ar_ready_o),
    .data_i  (r_push_word),
    .valid_o (r_valid_o),
    .ready_i (r_ready_i),
    .data_o  (r_word)
  );

  assign r_data_o = r_word[r_width-1:b_width];
  assign r_resp_o = resp_e'(r_word[b_width-1:0]);

endmodule

// File: hdl/axil_resp_buffer.sv
// Two-entry response buffer with valid/ready on both sides.
// Outputs come straight from flops, so no combinational path runs from the
// input side to the output side. Used for the B and R channels.
`timescale 1ns/1ns

module axil_resp_buffer #(
  parameter int unsigned WIDTH = 2
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [WIDTH-1:0] data_o
);

  // Slot A drives the outputs and always holds the oldest entry.
  // Slot B is the spill slot, only used while A is stalled.
  logic             a_full_q;
  logic             b_full_q;
  logic [WIDTH-1:0] a_data_q;
  logic [WIDTH-1:0] b_data_q;

  logic push;
  logic pop;
  logic a_load;
  logic b_load;

  // Room for a push as long as the spill slot is empty.
  // This only looks at flops, so ready_o is registered too.
  assign ready_o = ~b_full_q;
  assign valid_o = a_full_q;
  assign data_o  = a_data_q;

  assign push = valid_i & ready_o;
  assign pop  = a_full_q & ready_i;

  // A refills when it empties or drains, from B first to keep order.
  assign a_load = (pop | ~a_full_q) & (b_full_q | push);

  // B catches a push while A is held by the consumer.
  assign b_load = a_full_q & ~pop & push;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      // A stays full unless it drains with nothing behind it.
      a_full_q <= (a_full_q & ~pop) | b_full_q | push;
      // B empties on a pop, since its entry moves to A.
      b_full_q <= (b_full_q & ~pop) | b_load;
    end
  end

  // Payload flops.
  always_ff @(posedge clk_i) begin
    if (a_load) begin
      a_data_q <= b_full_q ? b_data_q : data_i;
    end
    if (b_load) begin
      b_data_q <= data_i;
    end
  end

endmodule

// File: hdl/regs_pkg.sv
// Register-side types of the AXI4-Lite register block.
// One register word, its index, and the flattened array seen on the hardware port.
`include "regs_config.svh"

package regs_pkg;

  // One register, narrower than the bus.
  typedef logic [`REGS_REG_WIDTH-1:0] reg_word_t;

  // Selects one of REGS_NUM registers.
  typedef logic [$clog2(`REGS_NUM)-1:0] reg_idx_t;

  // All registers, index 0 in the low word.
  typedef reg_word_t [`REGS_NUM-1:0] reg_array_t;

  // One flag per register.
  typedef logic [`REGS_NUM-1:0] reg_mask_t;

endpackage

// File: include/regs_config.svh
// Build-time configuration of the AXI4-Lite register block.
// Included by the packages and by every module that needs a size or a policy value.
`ifndef REGS_CONFIG_SVH
`define REGS_CONFIG_SVH

// Number of registers on the bus.
`define REGS_NUM 8

// Bus address and data widths.
`define REGS_ADDR_WIDTH 16
`define REGS_DATA_WIDTH 32

// Width of each register, at most the bus data width.
// Upper bus bits read as zero and are dropped on writes.
`define REGS_REG_WIDTH 20

// Base of the register region.
// Must be aligned to REGS_NUM * REGS_DATA_WIDTH/8 bytes.
`define REGS_BASE_ADDR 16'h0400

// Protection policy on AxPROT.
// Privileged accesses only; secure bit not required.
`define REGS_PRIV_ONLY 1'b1
`define REGS_SECURE_ONLY 1'b0

// One bit per register, set for AXI read-only.
// Registers 6 and 7 are read-only.
`define REGS_READ_ONLY 8'b1100_0000

// Reset value per register, register 7 leftmost.
`define REGS_RESET_VALUES {20'hF00D7, 20'hC0DE6, 20'h00005, 20'hABCDE, \
                           20'h12345, 20'h00000, 20'hFFFFF, 20'h5A5A5}

// Data word returned on a failed read.
`define REGS_ERR_DATA 32'hBA5E1E55

`endif

// File: run.sh
#!/usr/bin/env bash
# Builds the register block testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --timescale 1ns/1ns --top-module tb_axil_regs -f files.f

sim_out="$(./obj_dir/Vtb_axil_regs 2>&1 || true)"
echo "$sim_out"

if grep -q "No errors" <<< "$sim_out"; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// File: tests/axil_regs_golden.txt
// op addr prot data strb load_mask load_val stall exp_resp exp_rdata exp_reg_q
// op 1 write, 2 read, 0 ends the list; resp 0 OKAY, 2 SLVERR; stall 1 expects a held write
2 0400 1 00000000 0 00 00000 0 0 0005a5a5 5a5a5
2 0404 1 00000000 0 00 00000 0 0 000fffff fffff
2 0408 1 00000000 0 00 00000 0 0 00000000 00000
2 040c 1 00000000 0 00 00000 0 0 00012345 12345
2 0410 1 00000000 0 00 00000 0 0 000abcde abcde
2 0414 1 00000000 0 00 00000 0 0 00000005 00005
2 0418 1 00000000 0 00 00000 0 0 000c0de6 c0de6
2 041c 1 00000000 0 00 00000 0 0 000f00d7 f00d7
1 040c 1 deadbeef 5 00 00000 0 0 00000000 d23ef
2 040c 1 00000000 0 00 00000 0 0 000d23ef d23ef
1 0400 1 ffffffff c 00 00000 0 0 00000000 fa5a5
2 0400 1 00000000 0 00 00000 0 0 000fa5a5 fa5a5
1 0408 1 12345678 f 00 00000 0 0 00000000 45678
2 040a 1 00000000 0 00 00000 0 0 00045678 45678
1 0414 1 aaaaaaaa 2 00 00000 0 0 00000000 0aa05
1 0410 1 ffffffff 0 00 00000 0 0 00000000 abcde
1 0418 1 ffffffff f 00 00000 0 2 00000000 c0de6
1 041c 1 ffffffff f 00 00000 0 2 00000000 f00d7
1 0420 1 ffffffff f 00 00000 0 2 00000000 fa5a5
2 0420 1 00000000 0 00 00000 0 2 ba5e1e55 fa5a5
2 0004 1 00000000 0 00 00000 0 2 ba5e1e55 fffff
1 0404 0 ffffffff f 00 00000 0 2 00000000 fffff
2 0404 2 00000000 0 00 00000 0 2 ba5e1e55 fffff
1 0404 3 00012321 f 00 00000 0 0 00000000 12321
2 0404 7 00000000 0 00 00000 0 0 00012321 12321
1 0404 1 00077777 f 02 11111 1 0 00000000 77777
2 0404 1 00000000 0 00 00000 0 0 00077777 77777
1 0408 1 00033333 f 10 44444 0 0 00000000 33333
2 0410 1 00000000 0 00 00000 0 0 00044444 44444
1 0418 1 00000000 f 40 66666 0 2 00000000 66666
1 0404 0 00000000 f 02 22222 0 2 00000000 22222
2 0404 1 00000000 0 00 00000 0 0 00022222 22222
1 0400 1 000000a1 1 00 00000 0 0 00000000 fa5a1
1 0400 1 0000b200 2 00 00000 0 0 00000000 fb2a1
1 0400 1 00030000 4 00 00000 0 0 00000000 3b2a1
2 0400 1 00000000 0 00 00000 0 0 0003b2a1 3b2a1
2 0408 1 00000000 0 00 00000 0 0 00033333 33333
0 0000 0 00000000 0 00 00000 0 0 00000000 00000

// File: tests/tb_axil_regs.sv
// Testbench for the AXI4-Lite register block.
// Replays the golden vectors one access at a time and checks every B and R response
// in issue order, with random back-pressure on both response channels.
`timescale 1ns/1ns
`include "regs_config.svh"

module tb_axil_regs;
  import axil_pkg::*;
  import regs_pkg::*;

  // Eleven hex columns per golden line.
  localparam int fields = 11;
  localparam int max_vectors = 64;

  logic clk_i;
  logic reset_i;
  logic aw_valid_i;
  logic aw_ready_o;
  logic [`REGS_ADDR_WIDTH-1:0] aw_addr_i;
  prot_t aw_prot_i;
  logic w_valid_i;
  logic w_ready_o;
  data_t w_data_i;
  strb_t w_strb_i;
  logic b_valid_o;
  logic b_ready_i;
  resp_e b_resp_o;
  logic ar_valid_i;
  logic ar_ready_o;
  logic [`REGS_ADDR_WIDTH-1:0] ar_addr_i;
  prot_t ar_prot_i;
  logic r_valid_o;
  logic r_ready_i;
  data_t r_data_o;
  resp_e r_resp_o;
  reg_mask_t reg_load_i;
  reg_array_t reg_d_i;
  reg_array_t reg_q_o;

  logic [31:0] golden [0:fields*max_vectors-1];
  int num_vectors;
  int cycle_limit;
  integer seed = 32'h4dfdb1cd;
  // Vector numbers still waiting for a response, oldest first.
  int b_vec_q[$];
  int r_vec_q[$];

  axil_regs i_dut (.*);

  function automatic logic [31:0] field_of(input int n, input int col);
    return golden[n*fields+col];
  endfunction

  task automatic report_failure();
    $display("Errors found");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %h, actual %h", name, expected, actual);
      report_failure();
    end
  endtask

  // Presents one access from the current falling edge until it is taken.
  task automatic run_vector(input int n);
    logic [31:0] addr;
    logic [31:0] prot;
    logic [31:0] strb;
    logic [31:0] mask;
    logic [31:0] lval;
    reg_idx_t idx;
    logic is_write;
    logic stall;
    logic load_on;
    logic ready;
    logic aw_done;
    logic w_done;
    int held;
    string tag;
    addr = field_of(n, 1);
    prot = field_of(n, 2);
    strb = field_of(n, 4);
    mask = field_of(n, 5);
    lval = field_of(n, 6);
    // Index sits above the two byte offset bits.
    idx = addr[4:2];
    is_write = (field_of(n, 0) == 32'd1);
    stall = (field_of(n, 7) != 32'd0);
    load_on = (mask != 32'd0);
    ready = 1'b0;
    aw_done = 1'b0;
    w_done = 1'b0;
    held = 0;
    tag = $sformatf("vector %0d", n);
    if (is_write) begin
      b_vec_q.push_back(n);
      aw_valid_i = 1'b1;
      aw_addr_i = addr[`REGS_ADDR_WIDTH-1:0];
      aw_prot_i = prot[2:0];
      w_valid_i = 1'b1;
      w_data_i = field_of(n, 3);
      w_strb_i = strb[3:0];
    end else begin
      r_vec_q.push_back(n);
      ar_valid_i = 1'b1;
      ar_addr_i = addr[`REGS_ADDR_WIDTH-1:0];
      ar_prot_i = prot[2:0];
    end
    // Same load value on every selected register.
    reg_load_i = mask[`REGS_NUM-1:0];
    for (int i = 0; i < `REGS_NUM; i++) begin
      reg_d_i[i] = lval[`REGS_REG_WIDTH-1:0];
    end
    while (!ready) begin
      #1;
      if (is_write) begin
        // AW and W each finish on their own handshake.
        aw_done = aw_done | aw_ready_o;
        w_done = w_done | w_ready_o;
        ready = aw_done & w_done;
      end else begin
        ready = ar_ready_o;
      end
      // Write to a register under load must wait.
      if (load_on && stall) begin
        check_value({tag, " aw_ready under load"}, 32'd0, 32'(aw_ready_o));
        check_value({tag, " w_ready under load"}, 32'd0, 32'(w_ready_o));
      end
      @(negedge clk_i);
      // A channel that has transferred drops its valid.
      if (aw_done) begin
        aw_valid_i = 1'b0;
      end
      if (w_done) begin
        w_valid_i = 1'b0;
      end
      if (load_on) begin
        for (int i = 0; i < `REGS_NUM; i++) begin
          if (mask[i]) begin
            check_value({tag, " loaded reg_q_o"}, lval, 32'(reg_q_o[i]));
          end
        end
        held++;
        // A stalling load is held three cycles, any other load for one.
        if (!stall || held == 3) begin
          reg_load_i = '0;
          load_on = 1'b0;
        end
      end
    end
    aw_valid_i = 1'b0;
    w_valid_i = 1'b0;
    ar_valid_i = 1'b0;
    check_value({tag, " reg_q_o"}, field_of(n, 10), 32'(reg_q_o[idx]));
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Random ready on B and R, and the in-order response check.
  initial begin : response_monitor
    int rnd;
    int n;
    b_ready_i = 1'b0;
    r_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      rnd = $random(seed);
      b_ready_i = rnd[0];
      r_ready_i = rnd[1];
      #1;
      if (b_valid_o && b_ready_i) begin
        if (b_vec_q.size() == 0) begin
          $display("A write response arrived with no write outstanding");
          report_failure();
        end else begin
          n = b_vec_q.pop_front();
          check_value($sformatf("vector %0d b_resp", n), field_of(n, 8), 32'(b_resp_o));
        end
      end
      if (r_valid_o && r_ready_i) begin
        if (r_vec_q.size() == 0) begin
          $display("A read response arrived with no read outstanding");
          report_failure();
        end else begin
          n = r_vec_q.pop_front();
          check_value($sformatf("vector %0d r_resp", n), field_of(n, 8), 32'(r_resp_o));
          check_value($sformatf("vector %0d r_data", n), field_of(n, 9), r_data_o);
        end
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles > cycle_limit) begin
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        report_failure();
      end
    end
  end

  initial begin : stimulus
    reset_i = 1'b1;
    aw_valid_i = 1'b0;
    aw_addr_i = '0;
    aw_prot_i = '0;
    w_valid_i = 1'b0;
    w_data_i = '0;
    w_strb_i = '0;
    ar_valid_i = 1'b0;
    ar_addr_i = '0;
    ar_prot_i = '0;
    reg_load_i = '0;
    reg_d_i = '0;
    $readmemh("tests/axil_regs_golden.txt", golden);
    // List ends at the first line with op 0.
    num_vectors = 0;
    while (num_vectors < max_vectors && field_of(num_vectors, 0) != 32'd0) begin
      num_vectors++;
    end
    cycle_limit = 8 + 40 * num_vectors;
    if (num_vectors == 0) begin
      $display("The golden file holds no vectors");
      report_failure();
    end
    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;
    for (int n = 0; n < num_vectors; n++) begin
      run_vector(n);
    end
    // Let buffered responses drain, then look for strays.
    while (b_vec_q.size() != 0 || r_vec_q.size() != 0) begin
      @(negedge clk_i);
    end
    repeat (10) @(negedge clk_i);
    $display("No errors");
    $finish;
  end

endmodule
